// File: Makefile
VERILATOR ?= verilator
TOP ?= cacheTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/blockTransfer.sv
`timescale 1ns/1ps

module blockTransfer import cachePkg::*; (
    input logic clk,
    input logic rst,
    input XferReq xferReq,
    output logic busy,
    output logic [offsetBits:0] progress,
    output SramReq sramPort,
    input MemWord sramRdata,
    output MemReq memReq,
    input MemWord memRdata
);

    logic writeBack;
    logic [sramAddrBits-1:0] sramBase;
    logic [extAddrBits-1:0] extBase;
    logic [offsetBits:0] issued;
    logic pendValid;
    logic [offsetBits-1:0] pendIdx;
    logic issuing;
    logic [offsetBits-1:0] sramIdx;
    logic [offsetBits-1:0] memIdx;

    assign issuing = busy && issued < blockWords;

    // Source side is read at the word counter, sink side written one cycle later
    assign sramIdx = writeBack ? issued[offsetBits-1:0] : pendIdx;
    assign memIdx = writeBack ? pendIdx : issued[offsetBits-1:0];

    always_comb begin
        sramPort.valid = writeBack ? issuing : pendValid;
        sramPort.we = !writeBack;
        sramPort.addr = {sramBase[sramAddrBits-1:offsetBits], sramIdx};
        sramPort.wdata = memRdata;
        sramPort.wmask = 4'hf;
        memReq.valid = writeBack ? pendValid : issuing;
        memReq.we = writeBack;
        memReq.addr = {extBase[extAddrBits-1:offsetBits], memIdx};
        memReq.wdata = sramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            pendValid <= 1'b0;
            progress <= '0;
        end else if (!busy) begin
            if (xferReq.valid) begin
                busy <= 1'b1;
                writeBack <= xferReq.we;
                sramBase <= xferReq.sramAddr;
                extBase <= xferReq.extAddr;
                issued <= '0;
                progress <= '0;
            end
        end else begin
            pendValid <= issuing;
            pendIdx <= issued[offsetBits-1:0];
            if (issuing) begin
                issued <= issued + 1'b1;
            end
            if (pendValid) begin
                progress <= progress + 1'b1;
            end
            // Last word completes
            if (!issuing && pendValid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: design/cacheController.sv
`timescale 1ns/1ps

module cacheController import cachePkg::*; (
    input logic clk,
    input logic rst,
    input AguUop loadIn,
    input StUop storeIn,
    input BranchProv branch,
    input logic fence,
    output logic [1:0] stall,
    output LoadResult loadOut,
    output logic fenceBusy,
    output logic [1:0][tagBits-1:0] lookupTag,
    input logic [1:0] lookupHit,
    input logic [1:0][entryBits-1:0] lookupEntry,
    output TableUpdate tableUpdate,
    input logic [entryBits-1:0] victimEntry,
    input EntryState victimState,
    input logic tableEmpty,
    output SramReq sramLoad,
    output SramReq sramStore,
    input MemWord sramRdata,
    output XferReq xferReq,
    input logic xferBusy,
    input logic [offsetBits:0] xferProgress
);

    typedef enum logic [1:0] {
        seqIdle,
        seqSearch,
        seqWriteBack,
        seqFill
    } SeqState;

    SeqState state;
    AguUop ldMiss;
    StUop stMiss;
    AguUop ldCur;
    StUop stCur;
    MgmtOp mgmtOp;
    logic [entryBits-1:0] mgmtEntry;
    logic [tagBits-1:0] mgmtTag;
    logic freeAvail;
    logic [entryBits-1:0] freeEntry;
    logic [tagBits-1:0] fillTag;
    logic fencePending;
    logic fenceActive;
    SqNum ldSqN;
    logic ldOutValid;
    SqNum ldOutSqN;

    logic ldCurValid, ldKill, ldEarly, ldHit;
    logic [entryBits-1:0] ldEntry;
    logic stCurValid, stIsMgmt, stWrite;
    logic ldPending, stPending;
    logic [tagBits-1:0] missTag;
    logic mgmtGo, doEvict, doAdvance, fillDone, fenceStart;

    function automatic logic younger(SqNum a, SqNum b);
        SqNum diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    function automatic MgmtOp decodeMgmt(logic [1:0] code);
        case (code)
            2'd0: return mgmtClean;
            2'd1: return mgmtInval;
            default: return mgmtFlush;
        endcase
    endfunction

    assign fenceBusy = fencePending || fenceActive;
    assign stall[0] = ldMiss.valid || fenceBusy;
    assign stall[1] = stMiss.valid || state != seqIdle || mgmtOp != mgmtNone || fenceBusy;

    // A waiting miss owns its port's lookup
    assign ldCur = ldMiss.valid ? ldMiss : loadIn;
    assign stCur = stMiss.valid ? stMiss : storeIn;
    assign ldCurValid = ldMiss.valid || (loadIn.valid && !stall[0]);
    assign stCurValid = stMiss.valid || (storeIn.valid && !stall[1]);
    assign lookupTag[0] = ldCur.addr[31:8];
    assign lookupTag[1] = stCur.addr[31:8];

    assign ldKill = branch.taken && younger(ldCur.sqN, branch.sqN);
    // Word already landed in the block being filled
    assign ldEarly = state == seqFill && !xferReq.valid && ldCur.addr[31:8] == fillTag
        && xferProgress > {1'b0, ldCur.addr[7:2]};
    assign ldHit = lookupHit[0] || ldEarly;
    assign ldEntry = lookupHit[0] ? lookupEntry[0] : freeEntry;

    assign stIsMgmt = !stMiss.valid && stCurValid && storeIn.wmask == 4'b0;
    assign stWrite = stCurValid && !stIsMgmt && lookupHit[1];

    assign ldPending = ldMiss.valid && !ldHit && !ldKill;
    assign stPending = stMiss.valid && !lookupHit[1];
    assign missTag = ldPending ? ldMiss.addr[31:8] : stMiss.addr[31:8];

    assign mgmtGo = state == seqIdle && mgmtOp != mgmtNone;
    assign fillDone = state == seqFill && !xferBusy && !xferReq.valid;
    assign doEvict = state == seqSearch && victimState.valid
        && (fenceActive || !victimState.used);
    assign doAdvance = state == seqSearch && !(fenceActive && tableEmpty)
        && (victimState.valid ? victimState.used && !fenceActive : fenceActive);
    assign fenceStart = fencePending && state == seqIdle && !ldMiss.valid && !stMiss.valid
        && mgmtOp == mgmtNone;

    assign loadOut = '{valid: ldOutValid, data: sramRdata, sqN: ldOutSqN};

    always_comb begin
        tableUpdate.set = fillDone;
        tableUpdate.inval = doEvict || (mgmtGo && mgmtOp != mgmtClean);
        tableUpdate.clean = mgmtGo && mgmtOp == mgmtClean;
        case (state)
            seqSearch: tableUpdate.seqEntry = victimEntry;
            seqFill: tableUpdate.seqEntry = freeEntry;
            default: tableUpdate.seqEntry = mgmtEntry;
        endcase
        tableUpdate.tag = fillTag;
        tableUpdate.touch = ldCurValid && !ldKill && lookupHit[0];
        tableUpdate.touchEntry = lookupEntry[0];
        tableUpdate.markDirty = stWrite;
        tableUpdate.dirtyEntry = lookupEntry[1];
        tableUpdate.advance = doAdvance;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            ldMiss.valid <= 1'b0;
            stMiss.valid <= 1'b0;
            sramLoad.valid <= 1'b0;
            sramStore.valid <= 1'b0;
            ldOutValid <= 1'b0;
            xferReq.valid <= 1'b0;
            mgmtOp <= mgmtNone;
            freeAvail <= 1'b1;
            freeEntry <= '0;
            fencePending <= 1'b0;
            fenceActive <= 1'b0;
        end else begin
            ldMiss <= ldCur;
            ldMiss.valid <= ldCurValid && !ldKill && !ldHit;
            sramLoad <= '{valid: ldCurValid && !ldKill && ldHit, we: 1'b0,
                addr: {ldEntry, ldCur.addr[7:2]}, wdata: '0, wmask: '0};
            ldSqN <= ldCur.sqN;
            ldOutValid <= sramLoad.valid && !(branch.taken && younger(ldSqN, branch.sqN));
            ldOutSqN <= ldSqN;

            stMiss <= stCur;
            stMiss.valid <= stCurValid && !stIsMgmt && !lookupHit[1];
            sramStore <= '{valid: stWrite, we: 1'b1, addr: {lookupEntry[1], stCur.addr[7:2]},
                wdata: stCur.data, wmask: stCur.wmask};
            // Management op on an absent block has nothing to do
            if (stIsMgmt && lookupHit[1]) begin
                mgmtOp <= decodeMgmt(storeIn.data[1:0]);
                mgmtEntry <= lookupEntry[1];
                mgmtTag <= storeIn.addr[31:8];
            end

            xferReq.valid <= 1'b0;
            case (state)
                seqIdle: begin
                    if (mgmtGo) begin
                        mgmtOp <= mgmtNone;
                        if (mgmtOp != mgmtInval) begin
                            xferReq <= '{1'b1, 1'b1, {mgmtEntry, 6'b0}, {mgmtTag, 6'b0}};
                            state <= seqWriteBack;
                        end
                    end else if (fenceActive || ((ldPending || stPending) && !freeAvail)) begin
                        state <= seqSearch;
                    end else if (ldPending || stPending) begin
                        xferReq <= '{1'b1, 1'b0, {freeEntry, 6'b0}, {missTag, 6'b0}};
                        fillTag <= missTag;
                        freeAvail <= 1'b0;
                        state <= seqFill;
                    end
                end
                seqSearch: begin
                    if (fenceActive && tableEmpty) begin
                        fenceActive <= 1'b0;
                        state <= seqIdle;
                    end else if (!victimState.valid && !fenceActive) begin
                        freeAvail <= 1'b1;
                        freeEntry <= victimEntry;
                        state <= seqIdle;
                    end else if (doEvict) begin
                        freeAvail <= 1'b1;
                        freeEntry <= victimEntry;
                        xferReq <= '{victimState.dirty, 1'b1, {victimEntry, 6'b0},
                            {victimState.tag, 6'b0}};
                        state <= victimState.dirty ? seqWriteBack : seqIdle;
                    end
                end
                seqWriteBack: begin
                    if (!xferBusy && !xferReq.valid) begin
                        state <= seqIdle;
                    end
                end
                default: begin
                    if (fillDone) begin
                        state <= seqIdle;
                    end
                end
            endcase

            if (fenceStart) begin
                fenceActive <= 1'b1;
                fencePending <= 1'b0;
            end else if (fence && !fenceBusy) begin
                fencePending <= 1'b1;
            end
        end
    end

endmodule

// File: design/cachePkg.sv
package cachePkg;

    localparam int numEntries = 16;
    localparam int entryBits = 4;
    localparam int blockWords = 64;
    localparam int offsetBits = 6;
    localparam int sramAddrBits = 10;
    localparam int extAddrBits = 30;
    localparam int tagBits = 24;

    typedef logic [5:0] SqNum;
    typedef logic [31:0] MemWord;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        SqNum sqN;
    } AguUop;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
        SqNum sqN;
    } StUop;

    typedef struct packed {
        logic taken;
        SqNum sqN;
    } BranchProv;

    typedef struct packed {
        logic valid;
        MemWord data;
        SqNum sqN;
    } LoadResult;

    typedef struct packed {
        logic valid;
        logic we;
        logic [sramAddrBits-1:0] addr;
        MemWord wdata;
        logic [3:0] wmask;
    } SramReq;

    // we set means write-back to external memory
    typedef struct packed {
        logic valid;
        logic we;
        logic [sramAddrBits-1:0] sramAddr;
        logic [extAddrBits-1:0] extAddr;
    } XferReq;

    typedef struct packed {
        logic valid;
        logic we;
        logic [extAddrBits-1:0] addr;
        MemWord wdata;
    } MemReq;

    typedef enum logic [1:0] {
        mgmtNone,
        mgmtClean,
        mgmtInval,
        mgmtFlush
    } MgmtOp;

    typedef struct packed {
        logic [tagBits-1:0] tag;
        logic valid;
        logic dirty;
        logic used;
    } EntryState;

    // Sequencer strobes share seqEntry; the pipelines have their own
    typedef struct packed {
        logic set;
        logic inval;
        logic clean;
        logic [entryBits-1:0] seqEntry;
        logic [tagBits-1:0] tag;
        logic touch;
        logic [entryBits-1:0] touchEntry;
        logic markDirty;
        logic [entryBits-1:0] dirtyEntry;
        logic advance;
    } TableUpdate;

endpackage

// File: design/cacheSram.sv
`timescale 1ns/1ps

module cacheSram import cachePkg::*; (
    input logic clk,
    input SramReq corePort [2],
    input SramReq xferPort,
    output MemWord coreRdata,
    output MemWord xferRdata
);

    MemWord mem [1 << sramAddrBits];
    SramReq portB;

    // Port A serves load reads, port B is shared by block transfers and store writes
    assign portB = xferPort.valid ? xferPort : corePort[1];

    always_ff @(posedge clk) begin
        if (corePort[0].valid) begin
            coreRdata <= mem[corePort[0].addr];
        end
        if (portB.valid) begin
            if (portB.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (portB.wmask[i]) begin
                        mem[portB.addr][8*i +: 8] <= portB.wdata[8*i +: 8];
                    end
                end
            end else begin
                xferRdata <= mem[portB.addr];
            end
        end
    end

endmodule

// File: design/cacheSubsystem.sv
`timescale 1ns/1ps

module cacheSubsystem import cachePkg::*; (
    input logic clk,
    input logic rst,
    input AguUop loadIn,
    input StUop storeIn,
    input BranchProv branch,
    input logic fence,
    output logic [1:0] stall,
    output LoadResult loadOut,
    output logic fenceBusy,
    output MemReq memReq,
    input MemWord memRdata
);

    logic [1:0][tagBits-1:0] lookupTag;
    logic [1:0] lookupHit;
    logic [1:0][entryBits-1:0] lookupEntry;
    TableUpdate tableUpdate;
    logic [entryBits-1:0] victimEntry;
    EntryState victimState;
    logic tableEmpty;
    // Index 0 load read, index 1 store write
    SramReq sramCore [2];
    MemWord sramRdata;
    XferReq xferReq;
    logic xferBusy;
    logic [offsetBits:0] xferProgress;
    SramReq xferSram;
    MemWord xferRdata;

    cacheController ctrl (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .branch(branch),
        .fence(fence),
        .stall(stall),
        .loadOut(loadOut),
        .fenceBusy(fenceBusy),
        .lookupTag(lookupTag),
        .lookupHit(lookupHit),
        .lookupEntry(lookupEntry),
        .tableUpdate(tableUpdate),
        .victimEntry(victimEntry),
        .victimState(victimState),
        .tableEmpty(tableEmpty),
        .sramLoad(sramCore[0]),
        .sramStore(sramCore[1]),
        .sramRdata(sramRdata),
        .xferReq(xferReq),
        .xferBusy(xferBusy),
        .xferProgress(xferProgress)
    );

    cacheTagTable tagTable (
        .clk(clk),
        .rst(rst),
        .lookupTag(lookupTag),
        .lookupHit(lookupHit),
        .lookupEntry(lookupEntry),
        .tableUpdate(tableUpdate),
        .victimEntry(victimEntry),
        .victimState(victimState),
        .tableEmpty(tableEmpty)
    );

    cacheSram sram (
        .clk(clk),
        .corePort(sramCore),
        .xferPort(xferSram),
        .coreRdata(sramRdata),
        .xferRdata(xferRdata)
    );

    blockTransfer xfer (
        .clk(clk),
        .rst(rst),
        .xferReq(xferReq),
        .busy(xferBusy),
        .progress(xferProgress),
        .sramPort(xferSram),
        .sramRdata(xferRdata),
        .memReq(memReq),
        .memRdata(memRdata)
    );

endmodule

// File: design/cacheTagTable.sv
`timescale 1ns/1ps

module cacheTagTable import cachePkg::*; (
    input logic clk,
    input logic rst,
    input logic [1:0][tagBits-1:0] lookupTag,
    output logic [1:0] lookupHit,
    output logic [1:0][entryBits-1:0] lookupEntry,
    input TableUpdate tableUpdate,
    output logic [entryBits-1:0] victimEntry,
    output EntryState victimState,
    output logic tableEmpty
);

    EntryState entries [numEntries];
    logic [entryBits-1:0] pointer;

    assign victimEntry = pointer;
    assign victimState = entries[pointer];

    always_comb begin
        tableEmpty = 1'b1;
        for (int i = 0; i < numEntries; i++) begin
            if (entries[i].valid) begin
                tableEmpty = 1'b0;
            end
        end
        // Fully associative compare, load port 0 and store port 1
        for (int p = 0; p < 2; p++) begin
            lookupHit[p] = 1'b0;
            lookupEntry[p] = '0;
            for (int i = 0; i < numEntries; i++) begin
                if (entries[i].valid && entries[i].tag == lookupTag[p]) begin
                    lookupHit[p] = 1'b1;
                    lookupEntry[p] = entryBits'(i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numEntries; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].dirty <= 1'b0;
                entries[i].used <= 1'b0;
            end
            pointer <= '0;
        end else begin
            if (tableUpdate.touch) begin
                entries[tableUpdate.touchEntry].used <= 1'b1;
            end
            if (tableUpdate.markDirty) begin
                entries[tableUpdate.dirtyEntry].used <= 1'b1;
                entries[tableUpdate.dirtyEntry].dirty <= 1'b1;
            end
            // Clock hand clears the used bit it passes over
            if (tableUpdate.advance) begin
                entries[pointer].used <= 1'b0;
                pointer <= pointer + 1'b1;
            end
            if (tableUpdate.set) begin
                entries[tableUpdate.seqEntry].tag <= tableUpdate.tag;
                entries[tableUpdate.seqEntry].valid <= 1'b1;
                entries[tableUpdate.seqEntry].used <= 1'b1;
                entries[tableUpdate.seqEntry].dirty <= 1'b0;
            end
            if (tableUpdate.clean) begin
                entries[tableUpdate.seqEntry].dirty <= 1'b0;
            end
            // Invalidate wins over a touch in the same cycle
            if (tableUpdate.inval) begin
                entries[tableUpdate.seqEntry].valid <= 1'b0;
                entries[tableUpdate.seqEntry].used <= 1'b0;
            end
        end
    end

endmodule

// File: sim.f
+incdir+tests
design/cachePkg.sv
design/cacheTagTable.sv
design/cacheController.sv
design/blockTransfer.sv
design/cacheSram.sv
design/cacheSubsystem.sv
tests/cacheTb.sv

// File: tests/cacheTests.svh
// Accepted at the first rising edge with stall low
task automatic sendLoad(input logic [31:0] address, input SqNum sqN);
    @(posedge clk);
    loadIn <= '{valid: 1'b1, addr: address, sqN: sqN};
    @(negedge clk);
    while (stall[0]) @(negedge clk);
    @(posedge clk);
    loadIn <= '0;
endtask

// Cycles counted from the acceptance edge
task automatic receiveLoad(output LoadResult result, output int cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!loadOut.valid);
    result = loadOut;
endtask

task automatic waitQuiet();
    @(negedge clk);
    while (stall != 2'b00) @(negedge clk);
endtask

task automatic loadAndCheck(input string name, input logic [31:0] address, output int cycles);
    LoadResult expected;
    LoadResult result;
    expected = '{valid: 1'b1, data: expectedWord(address), sqN: nextSeq()};
    sendLoad(address, expected.sqN);
    receiveLoad(result, cycles);
    checkLoad(name, expected, result);
    waitQuiet();
endtask

// Zero mask makes a management op selected by data
task automatic storeWord(input logic [31:0] address, input MemWord data, input logic [3:0] mask);
    if (mask != 4'h0) begin
        shadow[int'(wordIndex(address))] = mergeBytes(expectedWord(address), data, mask);
    end
    @(posedge clk);
    storeIn <= '{valid: 1'b1, addr: address, data: data, wmask: mask, sqN: nextSeq()};
    @(negedge clk);
    while (stall[1]) @(negedge clk);
    @(posedge clk);
    storeIn <= '0;
    waitQuiet();
endtask

task automatic loadWithBranch(input logic [31:0] address, input SqNum sqN, input SqNum brSq);
    @(posedge clk);
    loadIn <= '{valid: 1'b1, addr: address, sqN: sqN};
    branch <= '{taken: 1'b1, sqN: brSq};
    @(negedge clk);
    if (stall[0]) begin
        stopWithError("branch kill: load port stalled in the branch cycle");
    end
    @(posedge clk);
    loadIn <= '0;
    branch <= '0;
endtask

task automatic testMissThenHit();
    logic [9:0] blk;
    int cycles;
    blk = 10'd1;
    loadAndCheck("miss then hit", byteAddr(blk, 6'($urandom % 64)), cycles);
    if (cycles <= 2) begin
        stopWithError("miss then hit: load to a cold block returned as fast as a hit");
    end
    loadAndCheck("miss then hit", byteAddr(blk, 6'($urandom % 64)), cycles);
    if (cycles != 2) begin
        stopWithError($sformatf("mismatch in miss then hit: expected latency 2, actual %0d",
            cycles));
    end
endtask

task automatic testStoreThenLoad();
    logic [31:0] address;
    int cycles;
    address = byteAddr(10'd2, 6'($urandom % 64));
    storeWord(address, $urandom, 4'($urandom % 15 + 1));
    loadAndCheck("store then load", address, cycles);
endtask

task automatic testEviction();
    logic [31:0] addrs [17];
    MemWord data [17];
    logic [15:0] idx;
    int written;
    int cycles;
    for (int i = 0; i < 17; i++) begin
        addrs[i] = byteAddr(10'(100 + i), 6'($urandom % 64));
        data[i] = $urandom;
        storeWord(addrs[i], data[i], 4'hf);
    end
    // Sixteen entries hold at most sixteen of the blocks
    written = 0;
    for (int i = 0; i < 17; i++) begin
        idx = wordIndex(addrs[i]);
        if (extMem[idx] != pattern(idx)) begin
            checkWord("eviction write-back", data[i], extMem[idx]);
            written++;
        end
    end
    if (written == 0) begin
        stopWithError("eviction: no dirty block reached memory after 17 distinct blocks");
    end
    for (int i = 0; i < 17; i++) begin
        loadAndCheck("eviction reload", addrs[i], cycles);
    end
endtask

task automatic testManagementOps();
    logic [31:0] address;
    MemWord data;
    int cycles;
    address = byteAddr(10'd200, 6'($urandom % 64));
    storeWord(address, $urandom, 4'hf);
    storeWord(byteAddr(10'd200, 6'd0), 32'd1, 4'h0);
    shadow.delete(int'(wordIndex(address)));
    checkWord("invalidate memory", pattern(wordIndex(address)), extMem[wordIndex(address)]);
    loadAndCheck("invalidate reload", address, cycles);

    address = byteAddr(10'd201, 6'($urandom % 64));
    data = $urandom;
    storeWord(address, data, 4'hf);
    storeWord(byteAddr(10'd201, 6'd0), 32'd0, 4'h0);
    checkWord("clean memory", data, extMem[wordIndex(address)]);
    loadAndCheck("clean reload", address, cycles);

    address = byteAddr(10'd202, 6'($urandom % 64));
    data = $urandom;
    storeWord(address, data, 4'hf);
    storeWord(byteAddr(10'd202, 6'd0), 32'(2 + $urandom % 2), 4'h0);
    checkWord("flush memory", data, extMem[wordIndex(address)]);
    loadAndCheck("flush reload", address, cycles);
endtask

task automatic testFence();
    logic [31:0] addrs [4];
    int cycles;
    for (int i = 0; i < 4; i++) begin
        addrs[i] = byteAddr(10'(300 + i), 6'($urandom % 64));
        storeWord(addrs[i], $urandom, 4'hf);
    end
    @(posedge clk);
    fence <= 1'b1;
    @(posedge clk);
    fence <= 1'b0;
    @(negedge clk);
    if (!fenceBusy) begin
        stopWithError("fence: fenceBusy did not rise one cycle after fence");
    end
    while (fenceBusy) @(negedge clk);
    // Every dirty word must have left the cache
    foreach (shadow[k]) begin
        checkWord("fence write-back", shadow[k], extMem[k]);
    end
    for (int i = 0; i < 4; i++) begin
        loadAndCheck("fence reload", addrs[i], cycles);
        if (cycles <= 2) begin
            stopWithError("fence: load after the fence hit an emptied cache");
        end
    end
endtask

task automatic testBranchKill();
    SqNum brSq;
    logic [31:0] olderAddr;
    LoadResult expected;
    LoadResult result;
    int cycles;
    brSq = nextSeq();
    olderAddr = byteAddr(10'd401, 6'($urandom % 64));
    waitQuiet();
    loadWithBranch(byteAddr(10'd400, 6'($urandom % 64)), brSq + 6'd3, brSq);
    // Long enough for a full search, a write-back and a fill
    repeat (numEntries + 2 * (blockWords + 8)) begin
        @(negedge clk);
        if (loadOut.valid) begin
            stopWithError("branch kill: a load younger than the taken branch returned data");
        end
    end
    waitQuiet();
    expected = '{valid: 1'b1, data: expectedWord(olderAddr), sqN: brSq - 6'd2};
    loadWithBranch(olderAddr, expected.sqN, brSq);
    receiveLoad(result, cycles);
    checkLoad("branch kill older load", expected, result);
    waitQuiet();
endtask

// File: tests/cacheTb.sv
`timescale 1ns/1ps

module cacheTb import cachePkg::*; ();

    localparam int clkPeriod = 100;
    localparam int resetCycles = 5;
    // Upper bound on block transfers over all tests
    localparam int xferBudget = 140;
    localparam int watchdogCycles = xferBudget * (blockWords + 6) + 2000;

    logic clk;
    logic rst;
    AguUop loadIn;
    StUop storeIn;
    BranchProv branch;
    logic fence;
    logic [1:0] stall;
    LoadResult loadOut;
    logic fenceBusy;
    MemReq memReq;
    MemWord memRdata = '0;

    // External memory of 64K words
    MemWord extMem [1 << 16];
    // Latest stored value per word index
    MemWord shadow [int];
    SqNum seqCounter;

    cacheSubsystem dut (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .branch(branch),
        .fence(fence),
        .stall(stall),
        .loadOut(loadOut),
        .fenceBusy(fenceBusy),
        .memReq(memReq),
        .memRdata(memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Read data returns one cycle after the request
    always @(posedge clk) begin
        if (memReq.valid) begin
            if (memReq.we) begin
                extMem[memReq.addr[15:0]] <= memReq.wdata;
            end else begin
                memRdata <= extMem[memReq.addr[15:0]];
            end
        end
    end

    function automatic MemWord pattern(logic [15:0] w);
        return {w ^ 16'ha5c3, ~w};
    endfunction

    function automatic logic [15:0] wordIndex(logic [31:0] address);
        return address[17:2];
    endfunction

    function automatic logic [31:0] byteAddr(logic [9:0] blk, logic [5:0] off);
        return {14'b0, blk, off, 2'b00};
    endfunction

    function automatic MemWord expectedWord(logic [31:0] address);
        int idx;
        idx = int'(wordIndex(address));
        return shadow.exists(idx) ? shadow[idx] : pattern(wordIndex(address));
    endfunction

    function automatic MemWord mergeBytes(MemWord old, MemWord data, logic [3:0] mask);
        MemWord merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    function automatic SqNum nextSeq();
        seqCounter = seqCounter + 1'b1;
        return seqCounter;
    endfunction

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic checkLoad(input string name, input LoadResult expected,
            input LoadResult actual);
        if (actual !== expected) begin
            $write("mismatch in %s: expected valid %b data %h sqN %0d, ", name,
                expected.valid, expected.data, expected.sqN);
            $display("actual valid %b data %h sqN %0d", actual.valid, actual.data,
                actual.sqN);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkWord(input string name, input MemWord expected, input MemWord actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    `include "cacheTests.svh"

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", watchdogCycles);
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(12897));
        rst = 1'b1;
        loadIn = '0;
        storeIn = '0;
        branch = '0;
        fence = 1'b0;
        seqCounter = '0;
        for (int i = 0; i < (1 << 16); i++) begin
            extMem[i] = pattern(16'(i));
        end
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        testMissThenHit();
        testStoreThenLoad();
        testEviction();
        testManagementOps();
        testFence();
        testBranchKill();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
